/* rtl/sifhPassPkg.sv */
`default_nettype none

// ****************************************
// histogram pass selection
// ****************************************

package sifhPassPkg;

    // coarse pass bins by top sample bits
    // fine pass bins at unit resolution inside the window
    typedef enum logic {
        passCoarse = 1'b0,
        passFine   = 1'b1
    } passT;

endpackage

`default_nettype wire

/* rtl/sifhSeqPkg.sv */
`default_nettype none

// ****************************************
// sequencer states and drain length
// ****************************************

package sifhSeqPkg;

    // idle waits for the first sample of a pass
    // collect runs the counters
    // drain lets the pipeline empty
    // switch is the last busy cycle and flips the pass
    typedef enum logic [1:0] {
        seqIdle    = 2'd0,
        seqCollect = 2'd1,
        seqDrain   = 2'd2,
        seqSwitch  = 2'd3
    } seqStateT;

    // busy cycles after the last sample of a pass
    localparam int drainCycles = 4;

endpackage

`default_nettype wire

/* rtl/sifhSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module sifhSequencer
    import sifhPassPkg::*;
    import sifhSeqPkg::*;
#(
    parameter int pixelCount      = 4,
    parameter int samplesPerPixel = 4,
    parameter int acqCount        = 2,
    localparam int pixelW = (pixelCount > 1) ? $clog2(pixelCount) : 1
) (
    input  wire logic              clk,
    input  wire logic              combin_res,
    input  wire logic              wrEn,
    output logic                   accept,
    output logic      [pixelW-1:0] pixelIdx,
    output passT                   pass,
    output logic                   passEnd,
    output logic                   busy
);

    localparam int sampleW = (samplesPerPixel > 1) ? $clog2(samplesPerPixel) : 1;
    localparam int acqW    = (acqCount > 1) ? $clog2(acqCount) : 1;
    localparam int drainW  = (drainCycles > 2) ? $clog2(drainCycles - 1) : 1;

    // terminal counts
    localparam logic [sampleW-1:0] sampleLast = sampleW'(samplesPerPixel - 1);
    localparam logic [pixelW-1:0]  pixelLast  = pixelW'(pixelCount - 1);
    localparam logic [acqW-1:0]    acqLast    = acqW'(acqCount - 1);
    // drain state covers all busy cycles but the switch cycle
    localparam logic [drainW-1:0]  drainLast  = drainW'(drainCycles - 2);

    seqStateT            state;
    logic [sampleW-1:0]  sampleCnt;
    logic [pixelW-1:0]   pixelCnt;
    logic [acqW-1:0]     acqCnt;
    logic [drainW-1:0]   drainCnt;
    logic                lastSample;

    // ****************************************
    // handshake and status
    // ****************************************

    assign busy     = (state == seqDrain) || (state == seqSwitch);
    // wrEn while busy is dropped
    assign accept   = wrEn && !busy;
    assign passEnd  = (state == seqSwitch);
    assign pixelIdx = pixelCnt;

    // final sample of the final sweep
    assign lastSample = accept && (sampleCnt == sampleLast) &&
                        (pixelCnt == pixelLast) && (acqCnt == acqLast);

    // ****************************************
    // sample, pixel and sweep counters
    // ****************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
        end else if (accept) begin
            if (sampleCnt == sampleLast) begin
                sampleCnt <= '0;
                // next pixel, wrap into next sweep
                if (pixelCnt == pixelLast) begin
                    pixelCnt <= '0;
                    if (acqCnt == acqLast) begin
                        acqCnt <= '0;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // ****************************************
    // pass control FSM
    // ****************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state    <= seqIdle;
            drainCnt <= '0;
            pass     <= passCoarse;
        end else begin
            case (state)
                seqIdle: begin
                    if (lastSample) begin
                        state <= seqDrain;
                    end else if (accept) begin
                        state <= seqCollect;
                    end
                end
                seqCollect: begin
                    if (lastSample) begin
                        state <= seqDrain;
                    end
                end
                seqDrain: begin
                    // wait for the histogram pipeline to settle
                    if (drainCnt == drainLast) begin
                        drainCnt <= '0;
                        state    <= seqSwitch;
                    end else begin
                        drainCnt <= drainCnt + 1'b1;
                    end
                end
                seqSwitch: begin
                    state <= seqIdle;
                    pass  <= (pass == passCoarse) ? passFine : passCoarse;
                end
                default: state <= seqIdle;
            endcase
        end
    end

    // pass end lands in the last cycle of the drain window
    assert property (@(posedge clk) disable iff (!combin_res)
        $rose(busy) |-> ##(drainCycles - 1) passEnd);

    // pass end hands control back at the next edge
    assert property (@(posedge clk) disable iff (!combin_res)
        passEnd |=> !busy);

endmodule

`default_nettype wire

/* rtl/binDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module binDecoder
    import sifhPassPkg::*;
#(
    parameter int sampleWidth = 8,
    parameter int binBits     = 4,
    parameter int pixelCount  = 4,
    localparam int pixelW = (pixelCount > 1) ? $clog2(pixelCount) : 1
) (
    input  wire logic                   clk,
    input  wire logic                   combin_res,
    input  wire logic                   accept,
    input  wire logic [sampleWidth-1:0] sample,
    input  wire passT                   pass,
    input  wire logic [pixelW-1:0]      pixelIdx,
    input  wire logic [sampleWidth-1:0] winLowCur,
    output logic                        binValid,
    output logic      [binBits-1:0]     binAddr,
    output logic      [pixelW-1:0]      binPixel
);

    localparam int spanW = sampleWidth + 1;
    // window width, one extra bit so a full range window fits
    localparam logic [spanW-1:0] binSpan = spanW'(1) << binBits;

    logic [sampleWidth-1:0] offset;
    logic                   idleCode;
    logic                   inWindow;
    logic                   hit;
    logic [binBits-1:0]     addrNext;

    // all ones marks an idle slot on the sensor link
    assign idleCode = (sample == '1);

    // fine bin position relative to the low edge
    assign offset   = sample - winLowCur;
    // upper edge is exclusive
    assign inWindow = (sample >= winLowCur) && ({1'b0, offset} < binSpan);

    always_comb begin
        if (pass == passCoarse) begin
            // top bits only
            hit      = !idleCode;
            addrNext = sample[sampleWidth-1 -: binBits];
        end else begin
            hit      = !idleCode && inWindow;
            addrNext = offset[binBits-1:0];
        end
    end

    // ****************************************
    // decode register
    // ****************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= 1'b0;
        end else begin
            binValid <= accept && hit;
        end
    end

    // payload follows the accepted sample
    always_ff @(posedge clk) begin
        if (accept) begin
            binAddr  <= addrNext;
            binPixel <= pixelIdx;
        end
    end

endmodule

`default_nettype wire

/* rtl/histogramPeak.sv */
`timescale 1ns/1ns
`default_nettype none

module histogramPeak #(
    parameter int binBits    = 4,
    parameter int pixelCount = 4,
    parameter int countWidth = 8,
    localparam int pixelW = (pixelCount > 1) ? $clog2(pixelCount) : 1
) (
    input  wire logic                          clk,
    input  wire logic                          combin_res,
    input  wire logic                          binValid,
    input  wire logic [binBits-1:0]            binAddr,
    input  wire logic [pixelW-1:0]             binPixel,
    input  wire logic                          passEnd,
    output logic      [pixelCount*binBits-1:0] peakBinFlat
);

    localparam int binCount = 2 ** binBits;

    // bin counters, one histogram per pixel
    logic [countWidth-1:0] binCnt [pixelCount][binCount];
    // set once a bin holds a count from the current pass
    logic [binCount-1:0]   binUsed [pixelCount];

    // update register between count and write back
    logic                  updValid;
    logic [pixelW-1:0]     updPixel;
    logic [binBits-1:0]    updBin;
    logic [countWidth-1:0] updCount;

    logic                  sameBin;
    logic [countWidth-1:0] baseCount;
    logic [countWidth-1:0] nextCount;

    // running peak per pixel
    logic [countWidth-1:0] peakMax [pixelCount];
    logic [binBits-1:0]    peakBin [pixelCount];

    // ****************************************
    // count stage
    // ****************************************

    // previous sample not yet written back
    assign sameBin = updValid && (updPixel == binPixel) && (updBin == binAddr);

    always_comb begin
        if (sameBin) begin
            baseCount = updCount;
        end else if (binUsed[binPixel][binAddr]) begin
            baseCount = binCnt[binPixel][binAddr];
        end else begin
            // stale bin from an earlier pass reads as empty
            baseCount = '0;
        end
    end

    // saturate instead of wrapping
    assign nextCount = (baseCount == '1) ? baseCount : baseCount + 1'b1;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            updValid <= 1'b0;
        end else begin
            updValid <= binValid;
        end
    end

    always_ff @(posedge clk) begin
        if (binValid) begin
            updPixel <= binPixel;
            updBin   <= binAddr;
            updCount <= nextCount;
        end
    end

    // ****************************************
    // write back and peak tracking
    // ****************************************

    always_ff @(posedge clk) begin
        if (updValid) begin
            binCnt[updPixel][updBin] <= updCount;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < pixelCount; p++) begin
                binUsed[p] <= '0;
                peakMax[p] <= '0;
                peakBin[p] <= '0;
            end
        end else if (passEnd) begin
            // fresh histograms for the next pass
            for (int p = 0; p < pixelCount; p++) begin
                binUsed[p] <= '0;
                peakMax[p] <= '0;
                peakBin[p] <= '0;
            end
        end else if (updValid) begin
            binUsed[updPixel][updBin] <= 1'b1;
            // strictly greater, first bin to a count keeps it
            if (updCount > peakMax[updPixel]) begin
                peakMax[updPixel] <= updCount;
                peakBin[updPixel] <= updBin;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < pixelCount; p++) begin
            peakBinFlat[p*binBits +: binBits] = peakBin[p];
        end
    end

    // pixel index from the sequencer stays in range
    assert property (@(posedge clk) disable iff (!combin_res)
        binValid |-> (binPixel < pixelCount));

endmodule

`default_nettype wire

/* rtl/peakWindow.sv */
`timescale 1ns/1ns
`default_nettype none

module peakWindow
    import sifhPassPkg::*;
#(
    parameter int sampleWidth = 8,
    parameter int binBits     = 4,
    parameter int pixelCount  = 4,
    localparam int pixelW = (pixelCount > 1) ? $clog2(pixelCount) : 1
) (
    input  wire logic                              clk,
    input  wire logic                              combin_res,
    input  wire passT                              pass,
    input  wire logic                              passEnd,
    input  wire logic [pixelW-1:0]                 pixelIdx,
    input  wire logic [pixelCount*binBits-1:0]     peakBinFlat,
    output logic      [sampleWidth-1:0]            winLowCur,
    output logic      [pixelCount*sampleWidth-1:0] resultFlat,
    output logic                                   frameDone
);

    // one extra bit keeps center plus half from wrapping
    localparam int extW = sampleWidth + 1;
    localparam logic [extW-1:0] half   = extW'(1) << (binBits - 1);
    localparam logic [extW-1:0] maxVal = {1'b0, {sampleWidth{1'b1}}};
    // clamp for peaks near the top of the range
    localparam logic [extW-1:0] topLow = maxVal - extW'(1) - (half << 1);

    // low edge per pixel
    logic [sampleWidth-1:0] winLow [pixelCount];

    // ****************************************
    // window rule
    // ****************************************

    function automatic logic [sampleWidth-1:0] windowLow(input logic [binBits-1:0] bin);
        logic [extW-1:0] center;
        logic [extW-1:0] low;
        center = extW'(bin) << (sampleWidth - binBits);
        if (center <= half) begin
            low = '0;
        end else if ((center + half) > (maxVal - extW'(1))) begin
            low = topLow;
        end else begin
            low = center - half;
        end
        return low[sampleWidth-1:0];
    endfunction

    // decoder reads the edge of the pixel being accepted
    assign winLowCur = winLow[pixelIdx];

    // ****************************************
    // windows after coarse, results after fine
    // ****************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < pixelCount; p++) begin
                winLow[p] <= '0;
            end
            resultFlat <= '0;
            frameDone  <= 1'b0;
        end else begin
            frameDone <= passEnd && (pass == passFine);
            if (passEnd) begin
                for (int p = 0; p < pixelCount; p++) begin
                    if (pass == passCoarse) begin
                        winLow[p] <= windowLow(peakBinFlat[p*binBits +: binBits]);
                    end else begin
                        // fine bin is an offset from the low edge
                        resultFlat[p*sampleWidth +: sampleWidth] <=
                            winLow[p] + sampleWidth'(peakBinFlat[p*binBits +: binBits]);
                    end
                end
            end
        end
    end

    // every window stays inside the sample range
    for (genvar g = 0; g < pixelCount; g++) begin : gWinCheck
        assert property (@(posedge clk) disable iff (!combin_res)
            (extW'(winLow[g]) + (half << 1) - extW'(1)) <= maxVal);
    end

endmodule

`default_nettype wire

/* rtl/sifhTop.sv */
`timescale 1ns/1ns
`default_nettype none

module sifhTop
    import sifhPassPkg::*;
#(
    parameter int sampleWidth     = 8,
    parameter int binBits         = 4,
    parameter int pixelCount      = 4,
    parameter int samplesPerPixel = 4,
    parameter int acqCount        = 2,
    parameter int countWidth      = 8
) (
    input  wire logic                              clk,
    input  wire logic                              combin_res,
    input  wire logic                              wrEn,
    input  wire logic [sampleWidth-1:0]            sample,
    output logic                                   busy,
    output logic                                   frameDone,
    output logic      [pixelCount*sampleWidth-1:0] resultFlat
);

    localparam int pixelW = (pixelCount > 1) ? $clog2(pixelCount) : 1;

    // sequencer to datapath
    logic                          accept;
    logic [pixelW-1:0]             pixelIdx;
    passT                          pass;
    logic                          passEnd;

    // decode to histogram
    logic                          binValid;
    logic [binBits-1:0]            binAddr;
    logic [pixelW-1:0]             binPixel;

    // histogram and window feedback
    logic [pixelCount*binBits-1:0] peakBinFlat;
    logic [sampleWidth-1:0]        winLowCur;

    // ****************************************
    // block instances
    // ****************************************

    sifhSequencer #(
        .pixelCount(pixelCount), .samplesPerPixel(samplesPerPixel), .acqCount(acqCount)
    ) u_sequencer (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .accept(accept),
        .pixelIdx(pixelIdx), .pass(pass), .passEnd(passEnd), .busy(busy)
    );

    binDecoder #(
        .sampleWidth(sampleWidth), .binBits(binBits), .pixelCount(pixelCount)
    ) u_decoder (
        .clk(clk), .combin_res(combin_res), .accept(accept), .sample(sample),
        .pass(pass), .pixelIdx(pixelIdx), .winLowCur(winLowCur),
        .binValid(binValid), .binAddr(binAddr), .binPixel(binPixel)
    );

    histogramPeak #(
        .binBits(binBits), .pixelCount(pixelCount), .countWidth(countWidth)
    ) u_histogram (
        .clk(clk), .combin_res(combin_res), .binValid(binValid), .binAddr(binAddr),
        .binPixel(binPixel), .passEnd(passEnd), .peakBinFlat(peakBinFlat)
    );

    peakWindow #(
        .sampleWidth(sampleWidth), .binBits(binBits), .pixelCount(pixelCount)
    ) u_window (
        .clk(clk), .combin_res(combin_res), .pass(pass), .passEnd(passEnd),
        .pixelIdx(pixelIdx), .peakBinFlat(peakBinFlat), .winLowCur(winLowCur),
        .resultFlat(resultFlat), .frameDone(frameDone)
    );

endmodule

`default_nettype wire

/* test/sifhTbModel.svh */
`ifndef SIFH_TB_MODEL_SVH
`define SIFH_TB_MODEL_SVH

// ****************************************
// expected values from the peak and window rules
// ****************************************

// one pixel over one pass, strict greater so the first bin to the top count wins
function automatic int histPeak(input int f, input int pixel, input bit fine, input int low);
    int cnt [binCount];
    int best;
    int bestBin;
    int value;
    int bin;
    best    = 0;
    bestBin = 0;
    foreach (cnt[b]) begin
        cnt[b] = 0;
    end
    for (int i = 0; i < passLen; i++) begin
        value = fine ? fineTab[f][i] : coarseTab[f][i];
        bin   = -1;
        // idle code never counts
        if ((((i / samplesPerPixel) % pixelCount) == pixel) && (value != maxSample)) begin
            if (!fine) begin
                bin = value >> (sampleWidth - binBits);
            end else if ((value >= low) && (value < low + binCount)) begin
                // upper edge exclusive
                bin = value - low;
            end
        end
        if (bin >= 0) begin
            cnt[bin]++;
            if (cnt[bin] > best) begin
                best    = cnt[bin];
                bestBin = bin;
            end
        end
    end
    return bestBin;
endfunction

// coarse bin from the top sample bits
function automatic int coarsePeakBin(input int f, input int pixel);
    return histPeak(f, pixel, 1'b0, 0);
endfunction

// window placed around the coarse peak, clamped at both ends
function automatic int windowLowEdge(input int bin);
    int center;
    int half;
    center = bin << (sampleWidth - binBits);
    half   = 2 ** (binBits - 1);
    if (center <= half) begin
        return 0;
    end else if (center + half > maxSample - 1) begin
        return maxSample - 1 - 2 * half;
    end
    return center - half;
endfunction

// unit bins inside the window
function automatic int finePeakBin(input int f, input int pixel, input int low);
    return histPeak(f, pixel, 1'b1, low);
endfunction

`endif

/* test/sifhTb.sv */
`timescale 1ns/1ns
`default_nettype none

module sifhTb
    import sifhSeqPkg::*;
();

    localparam int sampleWidth     = 8;
    localparam int binBits         = 4;
    localparam int pixelCount      = 4;
    localparam int samplesPerPixel = 4;
    localparam int acqCount        = 2;
    localparam int countWidth      = 8;

    localparam int binCount    = 2 ** binBits;
    localparam int maxSample   = 2 ** sampleWidth - 1;
    localparam int passLen     = pixelCount * samplesPerPixel * acqCount;
    localparam int rowBits     = pixelCount * samplesPerPixel * sampleWidth;
    localparam int handFrames  = 4;
    localparam int frameCount  = 6;
    localparam int resetCycles = 16;
    // two cycles per sample covers the idle gaps
    localparam int cycleLimit  = 2 * frameCount * 2 * passLen
                               + (drainCycles + 2) * 2 * frameCount + resetCycles;

    logic                              clk;
    logic                              combin_res;
    logic                              wrEn;
    logic [sampleWidth-1:0]            sample;
    logic                              busy;
    logic                              frameDone;
    logic [pixelCount*sampleWidth-1:0] resultFlat;

    // ****************************************
    // stimulus table
    // ****************************************

    // one byte per sample of the first sweep, pixel 0 leftmost
    // second sweep plays each pixel's bytes in reverse
    // frames: clustered, clamped edges, discards, ties
    logic [rowBits-1:0] coarseRows [handFrames] = '{
        128'h52555754_1a23282c_a0a3a9ae_c1c2c370,
        128'h02050a0c_f0f4f8fa_1112181c_e1e2e3e4,
        128'hffffff35_ffffffff_808182ff_404f4142,
        128'h15251525_35356565_90a0b0c0_77777777
    };
    logic [rowBits-1:0] fineRows [handFrames] = '{
        128'h53535653_21212225_a2a4a4a7_c3c3c4c4,
        128'h0505070f_f2f2f5e9_090c0c17_dadcdce7,
        128'h50505031_ffffffff_8888887f_37484747,
        128'h20212021_5a60605a_b9c0c1c2_70717273
    };

    // full sample lists and expected results per frame
    int coarseTab [frameCount][passLen];
    int fineTab   [frameCount][passLen];
    int expLow    [frameCount][pixelCount];
    int expResult [frameCount][pixelCount];

    int unsigned lcgState       = 32'h737d57ac;
    int          errorCount     = 0;
    int          checkCount     = 0;
    int          cycleCount     = 0;
    int          frameDoneCount = 0;

    `include "sifhTbModel.svh"

    sifhTop #(
        .sampleWidth(sampleWidth), .binBits(binBits), .pixelCount(pixelCount),
        .samplesPerPixel(samplesPerPixel), .acqCount(acqCount), .countWidth(countWidth)
    ) i_dut (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .sample(sample),
        .busy(busy), .frameDone(frameDone), .resultFlat(resultFlat)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ****************************************
    // helpers
    // ****************************************

    function automatic int unsigned lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 8;
    endfunction

    // byte of a table row for sample slot i of the pass
    function automatic int rowSample(input logic [rowBits-1:0] row, input int i);
        int acq;
        int pos;
        int k;
        acq = i / (pixelCount * samplesPerPixel);
        pos = i % samplesPerPixel;
        if ((acq % 2) == 1) begin
            pos = samplesPerPixel - 1 - pos;
        end
        k = ((i / samplesPerPixel) % pixelCount) * samplesPerPixel + pos;
        return int'(row[rowBits - 1 - k * sampleWidth -: sampleWidth]);
    endfunction

    // cluster around a center, now and then an idle code
    function automatic int jitterSample(input int center);
        int s;
        s = center + int'(lcgNext() % 9) - 4;
        if (s < 0) begin
            s = 0;
        end else if (s > maxSample - 1) begin
            s = maxSample - 1;
        end
        if ((lcgNext() & 15) == 0) begin
            s = maxSample;
        end
        return s;
    endfunction

    task automatic buildTable();
        int center [pixelCount];
        int p;
        for (int f = 0; f < frameCount; f++) begin
            foreach (center[q]) begin
                center[q] = int'(lcgNext() % 256);
            end
            for (int i = 0; i < passLen; i++) begin
                p = (i / samplesPerPixel) % pixelCount;
                if (f < handFrames) begin
                    coarseTab[f][i] = rowSample(coarseRows[f], i);
                    fineTab[f][i]   = rowSample(fineRows[f], i);
                end else begin
                    coarseTab[f][i] = jitterSample(center[p]);
                    fineTab[f][i]   = jitterSample(center[p]);
                end
            end
            for (int q = 0; q < pixelCount; q++) begin
                expLow[f][q]    = windowLowEdge(coarsePeakBin(f, q));
                expResult[f][q] = expLow[f][q] + finePeakBin(f, q, expLow[f][q]);
            end
        end
    endtask

    task automatic checkEqual(input string what, input int got, input int exp);
        checkCount++;
        assert (got == exp) else begin
            errorCount++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // feed one pass, then check busy length and frame end
    task automatic runPass(input int f, input bit fine);
        int value;
        int busyLen;
        for (int i = 0; i < passLen; i++) begin
            @(negedge clk);
            while (busy) begin
                @(negedge clk);
            end
            // occasional idle cycle
            if ((lcgNext() & 7) == 0) begin
                wrEn = 1'b0;
                @(negedge clk);
            end
            value  = fine ? fineTab[f][i] : coarseTab[f][i];
            wrEn   = 1'b1;
            sample = value[sampleWidth-1:0];
        end
        @(negedge clk);
        wrEn   = 1'b0;
        sample = '0;
        checkEqual($sformatf("frame %0d busy after last sample", f), int'(busy), 1);
        busyLen = 0;
        while (busy) begin
            busyLen++;
            @(negedge clk);
        end
        checkEqual($sformatf("frame %0d busy length", f), busyLen, drainCycles);
        checkEqual($sformatf("frame %0d frameDone at pass end", f), int'(frameDone), int'(fine));
        if (fine) begin
            for (int p = 0; p < pixelCount; p++) begin
                checkEqual($sformatf("frame %0d pixel %0d result (low %0d)", f, p, expLow[f][p]),
                           int'(resultFlat[p*sampleWidth +: sampleWidth]), expResult[f][p]);
            end
        end
        @(negedge clk);
        checkEqual($sformatf("frame %0d frameDone width", f), int'(frameDone), 0);
    endtask

    // ****************************************
    // run control
    // ****************************************

    always @(negedge clk) begin
        if (frameDone) begin
            frameDoneCount <= frameDoneCount + 1;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not end within %0d cycles", cycleLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        combin_res = 1'b0;
        wrEn       = 1'b0;
        sample     = '0;
        buildTable();
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;
        repeat (2) begin
            @(negedge clk);
            checkEqual("busy after reset", int'(busy), 0);
            checkEqual("frameDone after reset", int'(frameDone), 0);
            checkEqual("resultFlat nonzero after reset", int'(resultFlat != '0), 0);
        end
        for (int f = 0; f < frameCount; f++) begin
            runPass(f, 1'b0);
            runPass(f, 1'b1);
        end
        checkEqual("frameDone pulse count", frameDoneCount, frameCount);
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+test
rtl/sifhPassPkg.sv
rtl/sifhSeqPkg.sv
rtl/sifhSequencer.sv
rtl/binDecoder.sv
rtl/histogramPeak.sv
rtl/peakWindow.sv
rtl/sifhTop.sv
test/sifhTb.sv

/* Makefile */
# Verilator build and run of the histogram peak finder testbench

VERILATOR ?= verilator
TOP       ?= sifhTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
